//--- include/armCtrl_params.svh
`ifndef ARMCTRL_PARAMS_SVH
`define ARMCTRL_PARAMS_SVH

// Datapath word width
`define ARM_XLEN 32

// NZCV condition flags
`define ARM_NFLAGS 4

// Writes to this register redirect the fetch
`define ARM_PC_REG 4'd15

`endif

//--- design/armCtrlPkg.sv
`default_nettype none

`include "armCtrl_params.svh"

package armCtrlPkg;

  // Data-processing view of the instruction word
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        immFlag;
    logic [3:0]  opcode;
    logic        setFlags;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dpFields_t;

  // Single data transfer view (LDR / STR)
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        immFlag;    // Set means register offset
    logic        preIndex;
    logic        up;
    logic        byteFlag;
    logic        writeBack;
    logic        load;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } memFields_t;

  typedef union packed {
    dpFields_t                dp;
    memFields_t               mem;
    logic [`ARM_XLEN-1:0]     raw;
  } instrWord_u;

  typedef enum logic [3:0] {
    DP_AND, DP_EOR, DP_SUB, DP_RSB, DP_ADD, DP_ADC, DP_SBC, DP_RSC,
    DP_TST, DP_TEQ, DP_CMP, DP_CMN, DP_ORR, DP_MOV, DP_BIC, DP_MVN
  } dpOpcode_e;

  // Subtraction is ALU_ADD with invertB
  typedef enum logic [2:0] {
    ALU_ADD, ALU_AND, ALU_OR, ALU_XOR, ALU_PASSB
  } aluOp_e;

  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL
  } condCode_e;

endpackage

`default_nettype wire

//--- design/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_params.svh"

module instrDecoder (
  input  armCtrlPkg::instrWord_u instr,
  output logic [1:0]             regSrc,
  output logic [1:0]             immSrc,
  output logic                   aluSrc,
  output logic                   memtoReg,
  output logic                   regWrite,
  output logic                   memWrite,
  output logic                   branch,
  output logic                   aluOp,
  output logic                   pcSrc,
  output logic [1:0]             flagWrite,
  output logic [3:0]             aluControl
);

  // Main decode on the op field
  always_comb begin
    regSrc   = 2'b00;
    immSrc   = 2'b00;
    aluSrc   = 1'b0;
    memtoReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    aluOp    = 1'b0;
    case (instr.dp.op)
      2'b00: begin                     // Data processing
        aluSrc   = instr.dp.immFlag;   // Immediate or register operand
        regWrite = 1'b1;
        aluOp    = 1'b1;
      end
      2'b01: begin                     // LDR / STR
        immSrc = 2'b01;                // 12-bit offset
        aluSrc = 1'b1;
        if (instr.mem.load) begin
          memtoReg = 1'b1;
          regWrite = 1'b1;
        end else begin
          regSrc   = 2'b10;            // Rd read as store data
          memWrite = 1'b1;
        end
      end
      2'b10: begin
        // Block transfers are not decoded
        if (instr.dp.immFlag) begin
          regSrc = 2'b01;              // PC as first operand
          immSrc = 2'b10;              // 24-bit word offset
          aluSrc = 1'b1;
          branch = 1'b1;
        end
      end
      default: begin
        // Unimplemented encodings keep all controls low
      end
    endcase
  end

  // ALU control and flag write for data processing
  always_comb begin
    if (aluOp) begin
      aluControl = instr.dp.opcode;
      flagWrite  = {instr.dp.setFlags, instr.dp.setFlags};
    end else begin
      aluControl = 4'b0100;            // ADD for address math
      flagWrite  = 2'b00;
    end
  end

  // Fetch redirect on branch or write to the PC
  assign pcSrc = branch | (regWrite & (instr.dp.rd == `ARM_PC_REG));

endmodule

`default_nettype wire

//--- design/aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
  input  logic                  aluOp,
  input  armCtrlPkg::dpOpcode_e opcode,
  input  logic [1:0]            prevCV,         // Stored {C, V}
  output armCtrlPkg::aluOp_e    aluOperation,
  output logic [2:0]            cvUpdate,
  output logic                  invertB,
  output logic                  reverseInputs,
  output logic                  aluCarry,
  output logic                  doNotWriteReg
);

  logic arith;
  logic carryFromFlag;
  logic carryOne;

  always_comb begin
    aluOperation = armCtrlPkg::ALU_ADD;
    if (aluOp) begin
      case (opcode)
        armCtrlPkg::DP_AND, armCtrlPkg::DP_TST, armCtrlPkg::DP_BIC:
          aluOperation = armCtrlPkg::ALU_AND;
        armCtrlPkg::DP_EOR, armCtrlPkg::DP_TEQ:
          aluOperation = armCtrlPkg::ALU_XOR;
        armCtrlPkg::DP_ORR:
          aluOperation = armCtrlPkg::ALU_OR;
        armCtrlPkg::DP_MOV, armCtrlPkg::DP_MVN:
          aluOperation = armCtrlPkg::ALU_PASSB;
        default:
          aluOperation = armCtrlPkg::ALU_ADD;
      endcase
    end
  end

  assign arith = (aluOperation == armCtrlPkg::ALU_ADD);

  // BIC and MVN use the inverted operand as well
  assign invertB = aluOp & (opcode inside {armCtrlPkg::DP_SUB, armCtrlPkg::DP_RSB,
                                           armCtrlPkg::DP_SBC, armCtrlPkg::DP_RSC,
                                           armCtrlPkg::DP_CMP, armCtrlPkg::DP_BIC,
                                           armCtrlPkg::DP_MVN});
  assign reverseInputs = aluOp & (opcode inside {armCtrlPkg::DP_RSB, armCtrlPkg::DP_RSC});

  assign carryFromFlag = opcode inside {armCtrlPkg::DP_ADC, armCtrlPkg::DP_SBC,
                                        armCtrlPkg::DP_RSC};
  assign carryOne      = opcode inside {armCtrlPkg::DP_SUB, armCtrlPkg::DP_RSB,
                                        armCtrlPkg::DP_CMP};
  assign aluCarry      = aluOp & (carryFromFlag ? prevCV[1] : carryOne);

  // Compare-type ops only set flags
  assign doNotWriteReg = aluOp & (opcode inside {armCtrlPkg::DP_TST, armCtrlPkg::DP_TEQ,
                                                 armCtrlPkg::DP_CMP, armCtrlPkg::DP_CMN});

  // [2] C from adder, [1] V from adder, [0] V passed through for logical ops
  assign cvUpdate = !aluOp ? 3'b000 :
                    arith  ? 3'b110 : {2'b00, prevCV[0]};

endmodule

`default_nettype wire

//--- design/condUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_params.svh"

module condUnit (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    en,
  input  armCtrlPkg::condCode_e   cond,
  input  logic [1:0]              flagWrite,   // {NZ, CV}
  input  logic [`ARM_NFLAGS-1:0]  aluFlags,
  output logic                    condEx,
  output logic [`ARM_NFLAGS-1:0]  flags
);

  logic n;
  logic z;
  logic c;
  logic v;

  assign {n, z, c, v} = flags;

  // Condition check against the stored flags
  always_comb begin
    case (cond)
      armCtrlPkg::COND_EQ: condEx = z;
      armCtrlPkg::COND_NE: condEx = ~z;
      armCtrlPkg::COND_CS: condEx = c;
      armCtrlPkg::COND_CC: condEx = ~c;
      armCtrlPkg::COND_MI: condEx = n;
      armCtrlPkg::COND_PL: condEx = ~n;
      armCtrlPkg::COND_VS: condEx = v;
      armCtrlPkg::COND_VC: condEx = ~v;
      armCtrlPkg::COND_HI: condEx = c & ~z;
      armCtrlPkg::COND_LS: condEx = ~c | z;
      armCtrlPkg::COND_GE: condEx = (n == v);
      armCtrlPkg::COND_LT: condEx = (n != v);
      armCtrlPkg::COND_GT: condEx = ~z & (n == v);
      armCtrlPkg::COND_LE: condEx = z | (n != v);
      armCtrlPkg::COND_AL: condEx = 1'b1;
      default:             condEx = 1'b0;   // NV never executes
    endcase
  end

  // NZCV register with NZ and CV loaded separately
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else if (en && condEx) begin
      if (flagWrite[1]) begin
        flags[3:2] <= aluFlags[3:2];
      end
      if (flagWrite[0]) begin
        flags[1:0] <= aluFlags[1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_params.svh"

module controller (
  input  logic                    clk,
  input  logic                    arstN,
  input  armCtrlPkg::instrWord_u  instrD,
  input  logic [`ARM_NFLAGS-1:0]  flagsE,
  input  logic                    stallE,
  input  logic                    flushE,
  input  logic                    stallM,
  input  logic                    stallW,
  input  logic                    flushW,
  output logic [1:0]              regSrcD,
  output logic [1:0]              immSrcD,
  output logic                    aluSrcE,
  output logic [3:0]              aluControlE,
  output armCtrlPkg::aluOp_e      aluOperationE,
  output logic                    invertBE,
  output logic                    reverseInputsE,
  output logic                    aluCarryE,
  output logic [2:0]              cvUpdateE,
  output logic                    branchTakenE,
  output logic                    memWriteM,
  output logic                    memtoRegE,
  output logic                    memtoRegM,
  output logic                    regWriteM,
  output logic                    memtoRegW,
  output logic                    regWriteW,
  output logic                    pcSrcW,
  output logic                    pcWrPendingF
);

  logic       aluSrcD;
  logic       memtoRegD;
  logic       regWriteD;
  logic       memWriteD;
  logic       branchD;
  logic       aluOpD;
  logic       pcSrcD;
  logic [1:0] flagWriteD;
  logic [3:0] aluControlD;

  logic       regWriteE;
  logic       memWriteE;
  logic       branchE;
  logic       pcSrcE;
  logic       aluOpE;
  logic [1:0] flagWriteE;
  logic [3:0] condE;
  logic       condExE;
  logic       doNotWriteRegE;
  logic [`ARM_NFLAGS-1:0] flagsStoredE;

  logic       regWriteGatedE;
  logic       memWriteGatedE;
  logic       pcSrcGatedE;
  logic       pcSrcM;

  instrDecoder u_instrDecoder (
    .instr      (instrD),
    .regSrc     (regSrcD),
    .immSrc     (immSrcD),
    .aluSrc     (aluSrcD),
    .memtoReg   (memtoRegD),
    .regWrite   (regWriteD),
    .memWrite   (memWriteD),
    .branch     (branchD),
    .aluOp      (aluOpD),
    .pcSrc      (pcSrcD),
    .flagWrite  (flagWriteD),
    .aluControl (aluControlD)
  );

  // Flush wins over stall in Execute
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {flagWriteE, branchE, memWriteE, regWriteE, pcSrcE, memtoRegE} <= '0;
    end else if (flushE) begin
      {flagWriteE, branchE, memWriteE, regWriteE, pcSrcE, memtoRegE} <= '0;
    end else if (!stallE) begin
      {flagWriteE, branchE, memWriteE, regWriteE, pcSrcE, memtoRegE} <=
        {flagWriteD, branchD, memWriteD, regWriteD, pcSrcD, memtoRegD};
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {aluSrcE, aluControlE, aluOpE, condE} <= '0;
    end else if (!stallE) begin
      {aluSrcE, aluControlE, aluOpE, condE} <= {aluSrcD, aluControlD, aluOpD, instrD.dp.cond};
    end
  end

  // aluControlE carries the opcode for data processing
  aluDecoder u_aluDecoder (
    .aluOp         (aluOpE),
    .opcode        (armCtrlPkg::dpOpcode_e'(aluControlE)),
    .prevCV        (flagsStoredE[1:0]),
    .aluOperation  (aluOperationE),
    .cvUpdate      (cvUpdateE),
    .invertB       (invertBE),
    .reverseInputs (reverseInputsE),
    .aluCarry      (aluCarryE),
    .doNotWriteReg (doNotWriteRegE)
  );

  condUnit u_condUnit (
    .clk       (clk),
    .arstN     (arstN),
    .en        (~stallE),
    .cond      (armCtrlPkg::condCode_e'(condE)),
    .flagWrite (flagWriteE),
    .aluFlags  (flagsE),
    .condEx    (condExE),
    .flags     (flagsStoredE)
  );

  // Writes and branches only when the condition passes
  assign branchTakenE   = branchE & condExE;
  assign memWriteGatedE = memWriteE & condExE;
  assign pcSrcGatedE    = pcSrcE & condExE;
  assign regWriteGatedE = regWriteE & condExE & ~doNotWriteRegE;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {memWriteM, memtoRegM, regWriteM, pcSrcM} <= '0;
    end else if (!stallM) begin
      {memWriteM, memtoRegM, regWriteM, pcSrcM} <=
        {memWriteGatedE, memtoRegE, regWriteGatedE, pcSrcGatedE};
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {memtoRegW, regWriteW, pcSrcW} <= '0;
    end else if (flushW) begin
      {memtoRegW, regWriteW, pcSrcW} <= '0;
    end else if (!stallW) begin
      {memtoRegW, regWriteW, pcSrcW} <= {memtoRegM, regWriteM, pcSrcM};
    end
  end

  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM;   // For the hazard unit

endmodule

`default_nettype wire

//--- design/armCtrlTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_params.svh"

module armCtrlTop (
  input  logic                    clk,
  input  logic                    arstN,
  input  armCtrlPkg::instrWord_u  instrD,
  input  logic [`ARM_NFLAGS-1:0]  flagsE,      // From the ALU
  input  logic                    stallE,
  input  logic                    flushE,
  input  logic                    stallM,
  input  logic                    stallW,
  input  logic                    flushW,
  output logic [1:0]              regSrcD,
  output logic [1:0]              immSrcD,
  output logic                    aluSrcE,
  output logic [3:0]              aluControlE,
  output armCtrlPkg::aluOp_e      aluOperationE,
  output logic                    invertBE,
  output logic                    reverseInputsE,
  output logic                    aluCarryE,
  output logic [2:0]              cvUpdateE,
  output logic                    branchTakenE,
  output logic                    memWriteM,
  output logic                    memtoRegE,
  output logic                    memtoRegM,
  output logic                    regWriteM,
  output logic                    memtoRegW,
  output logic                    regWriteW,
  output logic                    pcSrcW,
  output logic                    pcWrPendingF
);

  controller u_controller (
    .clk            (clk),
    .arstN          (arstN),
    .instrD         (instrD),
    .flagsE         (flagsE),
    .stallE         (stallE),
    .flushE         (flushE),
    .stallM         (stallM),
    .stallW         (stallW),
    .flushW         (flushW),
    .regSrcD        (regSrcD),
    .immSrcD        (immSrcD),
    .aluSrcE        (aluSrcE),
    .aluControlE    (aluControlE),
    .aluOperationE  (aluOperationE),
    .invertBE       (invertBE),
    .reverseInputsE (reverseInputsE),
    .aluCarryE      (aluCarryE),
    .cvUpdateE      (cvUpdateE),
    .branchTakenE   (branchTakenE),
    .memWriteM      (memWriteM),
    .memtoRegE      (memtoRegE),
    .memtoRegM      (memtoRegM),
    .regWriteM      (regWriteM),
    .memtoRegW      (memtoRegW),
    .regWriteW      (regWriteW),
    .pcSrcW         (pcSrcW),
    .pcWrPendingF   (pcWrPendingF)
  );

endmodule

`default_nettype wire

//--- tb/armCtrlTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "armCtrl_params.svh"

module armCtrlTb;

  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_CYCLES = 60;
  localparam int RANDOM_CYCLES   = 200;
  localparam int MAX_CYCLES      = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 50;

  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       memtoReg;
    logic       pcSrc;
    logic       aluOp;
    logic       aluSrc;
    logic [1:0] flagWrite;
    logic [3:0] aluControl;
  } ctrlBits_t;

  logic clk;
  logic arstN;
  armCtrlPkg::instrWord_u instrD;
  logic [3:0] flagsE;
  logic stallE, flushE, stallM, stallW, flushW;
  logic [1:0] regSrcD, immSrcD;
  logic aluSrcE, invertBE, reverseInputsE, aluCarryE, branchTakenE;
  logic [3:0] aluControlE;
  armCtrlPkg::aluOp_e aluOperationE;
  logic [2:0] cvUpdateE;
  logic memWriteM, memtoRegE, memtoRegM, regWriteM, memtoRegW, regWriteW, pcSrcW;
  logic pcWrPendingF;

  int errorCount;
  int cycleCount = 0;
  integer seed;
  string testName;
  logic [31:0] instrRnd;
  logic [31:0] ctlRnd;

  // Reference pipeline shadow
  ctrlBits_t dCtrl, refE, nextE;
  logic [3:0] refCondE;
  logic [3:0] refFlags;
  logic refPass, expInvertB, expReverse, expCarry, expNoWrite, expRegWriteE;
  logic [2:0] expCvUpdate;
  armCtrlPkg::aluOp_e expAluOperation;
  logic refMemWriteM, refMemtoRegM, refRegWriteM, refPcSrcM;
  logic refMemtoRegW, refRegWriteW, refPcSrcW;
  logic [15:0] expD, actD, expE, actE, expM, actM, expW, actW, expFlags, actFlags;

  armCtrlTop u_dut (
    .clk(clk), .arstN(arstN), .instrD(instrD), .flagsE(flagsE),
    .stallE(stallE), .flushE(flushE), .stallM(stallM), .stallW(stallW), .flushW(flushW),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcE(aluSrcE), .aluControlE(aluControlE),
    .aluOperationE(aluOperationE), .invertBE(invertBE), .reverseInputsE(reverseInputsE),
    .aluCarryE(aluCarryE), .cvUpdateE(cvUpdateE), .branchTakenE(branchTakenE),
    .memWriteM(memWriteM), .memtoRegE(memtoRegE), .memtoRegM(memtoRegM),
    .regWriteM(regWriteM), .memtoRegW(memtoRegW), .regWriteW(regWriteW),
    .pcSrcW(pcSrcW), .pcWrPendingF(pcWrPendingF)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic ctrlBits_t decodeRef(armCtrlPkg::instrWord_u w);
    ctrlBits_t c;
    c = '0;
    c.aluControl = 4'b0100;   // Add for address math
    case (w.dp.op)
      2'b00: begin
        c.regWrite   = 1'b1;
        c.aluOp      = 1'b1;
        c.aluSrc     = w.dp.immFlag;
        c.aluControl = w.dp.opcode;
        c.flagWrite  = {2{w.dp.setFlags}};
      end
      2'b01: begin
        c.aluSrc   = 1'b1;
        c.regWrite = w.mem.load;
        c.memtoReg = w.mem.load;
        c.memWrite = ~w.mem.load;
      end
      2'b10: begin
        c.branch = w.dp.immFlag;
        c.aluSrc = w.dp.immFlag;
      end
      default: c = c;
    endcase
    c.pcSrc = c.branch | (c.regWrite & (w.dp.rd == `ARM_PC_REG));
    return c;
  endfunction

  // Returns {regSrc, immSrc}
  function automatic logic [3:0] srcSelRef(armCtrlPkg::instrWord_u w);
    logic [3:0] s;
    s = 4'b0000;
    if (w.dp.op == 2'b01) begin
      s = w.mem.load ? 4'b0001 : 4'b1001;   // STR reads Rd as data
    end else if (w.dp.op == 2'b10 && w.dp.immFlag) begin
      s = 4'b0110;                          // PC base and 24-bit offset
    end
    return s;
  endfunction

  function automatic logic condRule(logic [3:0] cond, logic [3:0] f);
    logic n, z, c, v;
    {n, z, c, v} = f;
    case (cond)
      armCtrlPkg::COND_EQ: return z;
      armCtrlPkg::COND_NE: return ~z;
      armCtrlPkg::COND_CS: return c;
      armCtrlPkg::COND_CC: return ~c;
      armCtrlPkg::COND_MI: return n;
      armCtrlPkg::COND_PL: return ~n;
      armCtrlPkg::COND_VS: return v;
      armCtrlPkg::COND_VC: return ~v;
      armCtrlPkg::COND_HI: return c & ~z;
      armCtrlPkg::COND_LS: return ~c | z;
      armCtrlPkg::COND_GE: return n == v;
      armCtrlPkg::COND_LT: return n != v;
      armCtrlPkg::COND_GT: return ~z & (n == v);
      armCtrlPkg::COND_LE: return z | (n != v);
      armCtrlPkg::COND_AL: return 1'b1;
      default:             return 1'b0;
    endcase
  endfunction

  function automatic armCtrlPkg::aluOp_e aluOpRef(logic aluOp, logic [3:0] opc);
    if (!aluOp) begin
      return armCtrlPkg::ALU_ADD;
    end
    case (opc)
      armCtrlPkg::DP_AND, armCtrlPkg::DP_TST, armCtrlPkg::DP_BIC: return armCtrlPkg::ALU_AND;
      armCtrlPkg::DP_EOR, armCtrlPkg::DP_TEQ:                     return armCtrlPkg::ALU_XOR;
      armCtrlPkg::DP_ORR:                                         return armCtrlPkg::ALU_OR;
      armCtrlPkg::DP_MOV, armCtrlPkg::DP_MVN:                     return armCtrlPkg::ALU_PASSB;
      default:                                                    return armCtrlPkg::ALU_ADD;
    endcase
  endfunction

  assign dCtrl = decodeRef(instrD);

  always_comb begin
    nextE = stallE ? refE : dCtrl;
    if (flushE) begin         // Flush beats stall for control bits
      nextE.regWrite  = 1'b0;
      nextE.memWrite  = 1'b0;
      nextE.branch    = 1'b0;
      nextE.memtoReg  = 1'b0;
      nextE.pcSrc     = 1'b0;
      nextE.flagWrite = 2'b00;
    end
  end

  always_comb begin
    refPass         = condRule(refCondE, refFlags);
    expAluOperation = aluOpRef(refE.aluOp, refE.aluControl);
    expInvertB      = refE.aluOp & (refE.aluControl inside {armCtrlPkg::DP_SUB,
                      armCtrlPkg::DP_RSB, armCtrlPkg::DP_SBC, armCtrlPkg::DP_RSC,
                      armCtrlPkg::DP_CMP, armCtrlPkg::DP_BIC, armCtrlPkg::DP_MVN});
    expReverse      = refE.aluOp & (refE.aluControl inside {armCtrlPkg::DP_RSB,
                      armCtrlPkg::DP_RSC});
    if (refE.aluControl inside {armCtrlPkg::DP_ADC, armCtrlPkg::DP_SBC, armCtrlPkg::DP_RSC}) begin
      expCarry = refE.aluOp & refFlags[1];   // Stored C
    end else begin
      expCarry = refE.aluOp & (refE.aluControl inside {armCtrlPkg::DP_SUB,
                 armCtrlPkg::DP_RSB, armCtrlPkg::DP_CMP});
    end
    if (!refE.aluOp) begin
      expCvUpdate = 3'b000;
    end else if (refE.aluControl inside {armCtrlPkg::DP_SUB, armCtrlPkg::DP_RSB,
                 armCtrlPkg::DP_ADD, armCtrlPkg::DP_ADC, armCtrlPkg::DP_SBC,
                 armCtrlPkg::DP_RSC, armCtrlPkg::DP_CMP, armCtrlPkg::DP_CMN}) begin
      expCvUpdate = 3'b110;                  // C and V from the adder
    end else begin
      expCvUpdate = {2'b00, refFlags[0]};    // Stored V passes through
    end
    expNoWrite   = refE.aluOp & (refE.aluControl inside {armCtrlPkg::DP_TST,
                   armCtrlPkg::DP_TEQ, armCtrlPkg::DP_CMP, armCtrlPkg::DP_CMN});
    expRegWriteE = refE.regWrite & refPass & ~expNoWrite;
  end

  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      refE     <= '0;
      refCondE <= '0;
      refFlags <= '0;
      {refMemWriteM, refMemtoRegM, refRegWriteM, refPcSrcM} <= '0;
      {refMemtoRegW, refRegWriteW, refPcSrcW} <= '0;
    end else begin
      refE <= nextE;
      if (!stallE) begin
        refCondE <= instrD.dp.cond;
      end
      if (!stallE && refPass && refE.flagWrite[1]) begin
        refFlags[3:2] <= flagsE[3:2];   // N and Z
      end
      if (!stallE && refPass && refE.flagWrite[0]) begin
        refFlags[1:0] <= flagsE[1:0];   // C and V
      end
      if (!stallM) begin
        {refMemWriteM, refMemtoRegM, refRegWriteM, refPcSrcM} <=
          {refE.memWrite & refPass, refE.memtoReg, expRegWriteE, refE.pcSrc & refPass};
      end
      if (flushW) begin
        {refMemtoRegW, refRegWriteW, refPcSrcW} <= '0;
      end else if (!stallW) begin
        {refMemtoRegW, refRegWriteW, refPcSrcW} <= {refMemtoRegM, refRegWriteM, refPcSrcM};
      end
    end
  end

  assign expD = {11'b0, srcSelRef(instrD), dCtrl.pcSrc | refE.pcSrc | refPcSrcM};
  assign actD = {11'b0, regSrcD, immSrcD, pcWrPendingF};
  assign expE = {expCvUpdate, refE.aluSrc, refE.aluControl, expAluOperation, expInvertB,
                 expReverse, expCarry, refE.branch & refPass, refE.memtoReg};
  assign actE = {cvUpdateE, aluSrcE, aluControlE, aluOperationE, invertBE, reverseInputsE,
                 aluCarryE, branchTakenE, memtoRegE};
  assign expM = {13'b0, refMemWriteM, refMemtoRegM, refRegWriteM};
  assign actM = {13'b0, memWriteM, memtoRegM, regWriteM};
  assign expW = {13'b0, refMemtoRegW, refRegWriteW, refPcSrcW};
  assign actW = {13'b0, memtoRegW, regWriteW, pcSrcW};
  assign expFlags = {12'b0, refFlags};
  assign actFlags = {12'b0, u_dut.u_controller.flagsStoredE};   // NZCV

  task automatic reportMismatch(input string what, input logic [15:0] expVal,
                                input logic [15:0] actVal);
    errorCount++;
    $display("ERROR %s %s: expected %h, actual %h", testName, what, expVal, actVal);
  endtask

  assert property (@(posedge clk) expD == actD)
    else reportMismatch("D stage", $sampled(expD), $sampled(actD));
  assert property (@(posedge clk) expE == actE)
    else reportMismatch("E stage", $sampled(expE), $sampled(actE));
  assert property (@(posedge clk) expM == actM)
    else reportMismatch("M stage", $sampled(expM), $sampled(actM));
  assert property (@(posedge clk) expW == actW)
    else reportMismatch("W stage", $sampled(expW), $sampled(actW));
  assert property (@(posedge clk) expFlags == actFlags)
    else reportMismatch("NZCV", $sampled(expFlags), $sampled(actFlags));

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= MAX_CYCLES) begin
      $display("Timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // cond, {op, immFlag}, opcode+S or P U B W L, rd
  function automatic armCtrlPkg::instrWord_u encode(logic [3:0] cond, logic [2:0] opImm,
                                                    logic [4:0] mid, logic [3:0] rd);
    return {cond, opImm, mid, 4'd2, rd, 12'h01c};
  endfunction

  function automatic armCtrlPkg::instrWord_u randomInstr(logic [31:0] rnd);
    armCtrlPkg::instrWord_u w;
    w.raw = rnd;
    if (w.dp.cond == 4'hF) begin
      w.dp.cond = 4'hE;       // No NV
    end
    if (w.dp.op == 2'b11) begin
      w.dp.op = 2'b00;
    end
    if (w.dp.op == 2'b10) begin
      w.dp.immFlag = 1'b1;    // B only
    end
    return w;
  endfunction

  // hold is {stallE, flushE, stallM, stallW, flushW}
  task automatic applyCycle(input armCtrlPkg::instrWord_u w, input logic [3:0] f,
                            input logic [4:0] hold);
    @(negedge clk);
    instrD = w;
    flagsE = f;
    {stallE, flushE, stallM, stallW, flushW} = hold;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) applyCycle('0, 4'h0, 5'b0);
  endtask

  initial begin
    seed       = 56977;
    errorCount = 0;
    testName   = "reset";
    arstN      = 1'b0;
    instrD     = '0;
    flagsE     = 4'h0;
    {stallE, flushE, stallM, stallW, flushW} = 5'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    idleCycles(2);

    testName = "dataProc";
    for (int op = 0; op < 16; op++) begin
      applyCycle(encode(armCtrlPkg::COND_AL, 3'b001, {op[3:0], 1'b0}, 4'd1), 4'h0, 5'b0);
    end
    idleCycles(3);

    testName = "flags";   // Flags for an instruction arrive one cycle after it
    applyCycle(encode(armCtrlPkg::COND_AL, 3'b001, {armCtrlPkg::DP_CMP, 1'b1}, 4'd0), 4'h0, 5'b0);
    applyCycle(encode(armCtrlPkg::COND_EQ, 3'b101, 5'b0, 4'd0), 4'b0100, 5'b0);
    applyCycle(encode(armCtrlPkg::COND_NE, 3'b001, {armCtrlPkg::DP_ADD, 1'b1}, 4'd2), 4'hF, 5'b0);
    applyCycle(encode(armCtrlPkg::COND_NE, 3'b101, 5'b0, 4'd0), 4'hF, 5'b0);
    applyCycle(encode(armCtrlPkg::COND_AL, 3'b001, {armCtrlPkg::DP_ADD, 1'b1}, 4'd2), 4'h0, 5'b0);
    applyCycle(encode(armCtrlPkg::COND_AL, 3'b001, {armCtrlPkg::DP_ADC, 1'b0}, 4'd3), 4'hA, 5'b0);
    applyCycle(encode(armCtrlPkg::COND_GT, 3'b001, {armCtrlPkg::DP_MOV, 1'b0}, 4'd4), 4'h0, 5'b0);
    applyCycle(encode(armCtrlPkg::COND_LT, 3'b001, {armCtrlPkg::DP_MOV, 1'b0}, 4'd4), 4'h0, 5'b0);
    applyCycle(encode(armCtrlPkg::COND_HI, 3'b101, 5'b0, 4'd0), 4'h0, 5'b0);
    idleCycles(3);

    testName = "memory";
    applyCycle(encode(armCtrlPkg::COND_AL, 3'b010, 5'b11000, 4'd5), 4'h0, 5'b0);   // STR
    applyCycle(encode(armCtrlPkg::COND_AL, 3'b010, 5'b11001, 4'd6), 4'h0, 5'b0);   // LDR
    applyCycle(encode(armCtrlPkg::COND_EQ, 3'b010, 5'b11000, 4'd5), 4'h0, 5'b0);
    applyCycle(encode(armCtrlPkg::COND_AL, 3'b010, 5'b11001, 4'd15), 4'h0, 5'b0);
    idleCycles(3);

    testName = "control";
    applyCycle(encode(armCtrlPkg::COND_AL, 3'b101, 5'b0, 4'd0), 4'h0, 5'b0);
    applyCycle(encode(armCtrlPkg::COND_AL, 3'b001, {armCtrlPkg::DP_MOV, 1'b0}, 4'd15), 4'h0, 5'b0);
    idleCycles(3);

    testName = "stallFlush";
    applyCycle(encode(armCtrlPkg::COND_AL, 3'b001, {armCtrlPkg::DP_ADD, 1'b1}, 4'd1), 4'h0, 5'b0);
    applyCycle('0, 4'h5, 5'b10000);       // ADDS held in E
    applyCycle('0, 4'h5, 5'b10000);
    applyCycle(encode(armCtrlPkg::COND_AL, 3'b101, 5'b0, 4'd0), 4'h3, 5'b0);
    applyCycle(encode(armCtrlPkg::COND_AL, 3'b010, 5'b11001, 4'd7), 4'h0, 5'b01000);
    applyCycle('0, 4'h0, 5'b00001);
    applyCycle('0, 4'h0, 5'b00100);
    applyCycle('0, 4'h0, 5'b00010);
    applyCycle(encode(armCtrlPkg::COND_AL, 3'b010, 5'b11000, 4'd8), 4'h0, 5'b11000);
    idleCycles(3);

    testName = "random";
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      instrRnd = $random(seed);
      ctlRnd   = $random(seed);
      applyCycle(randomInstr(instrRnd), ctlRnd[3:0],
                 {ctlRnd[7:5] == 3'd0, ctlRnd[10:8] == 3'd0, ctlRnd[13:11] == 3'd0,
                  ctlRnd[16:14] == 3'd0, ctlRnd[19:17] == 3'd0});
    end

    testName = "drain";
    idleCycles(4);
    @(negedge clk);
    $display("Run complete with %0d failed checks", errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
design/armCtrlPkg.sv
design/instrDecoder.sv
design/aluDecoder.sv
design/condUnit.sv
design/controller.sv
design/armCtrlTop.sv
tb/armCtrlTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module armCtrlTb -Mdir obj_dir -o armCtrlSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOutput="$(./obj_dir/armCtrlSim)"
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "Finished with no errors" <<< "$simOutput"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
